// ==== filelist.f ====
+incdir+.
dma_pkg.sv
beat_fifo.sv
burst_pack.sv
burst_align.sv
dma_ctrl.sv
dma_subsys.sv
tb_dma_subsys.sv

// ==== Makefile ====
TOP := tb_dma_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f filelist.f --top-module dma_subsys

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// ==== tb_dma_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module tb_dma_subsys import dma_pkg::*; ();

    localparam int n_tests = 10;
    localparam int words   = 256;  // Memory model size

    logic                        clk = 1'b0;
    logic                        rst;
    len_t                        addr;
    len_t                        length;
    logic                        read_not_write;
    logic                        start;
    logic                        ready;
    logic [`DMA_DATA_W-1:0]      data_in;
    logic                        valid_in;
    logic                        ready_in;
    logic [`DMA_DATA_W-1:0]      data_out;
    logic                        valid_out;
    logic                        ready_out;
    logic                        mem_cmd_valid;
    logic                        mem_cmd_ready;
    logic                        mem_cmd_write;
    logic [`DMA_LEN_W-3:0]       mem_cmd_addr;
    burst_len_t                  mem_cmd_len;
    logic [`DMA_DATA_W-1:0]      mem_wdata;
    logic [`DMA_DATA_W/8-1:0]    mem_wstrb;
    logic                        mem_wlast;
    logic                        mem_wvalid;
    logic                        mem_wready;
    logic [`DMA_DATA_W-1:0]      mem_rdata;
    logic                        mem_rlast;
    logic                        mem_rvalid;

    // Test table
    string t_name [n_tests] = '{"aligned_write", "unaligned_write_o1", "unaligned_write_o2",
                                "unaligned_write_o3", "single_byte_write", "long_write",
                                "aligned_read", "unaligned_read_o2", "unaligned_read_o3",
                                "long_read"};
    bit    t_rnw  [n_tests] = '{0, 0, 0, 0, 0, 0, 1, 1, 1, 1};
    int    t_addr [n_tests] = '{'h040, 'h101, 'h0a2, 'h0c3, 'h123, 'h201,
                                'h040, 'h0a2, 'h103, 'h105};
    int    t_len  [n_tests] = '{32, 7, 13, 22, 1, 400, 16, 13, 6, 450};

    logic [31:0] mem       [words];
    logic [31:0] prior_mem [words];  // Image before the running transfer
    logic [7:0]  src_bytes [$];
    logic [31:0] in_q      [$];
    logic [31:0] rx_q      [$];
    logic [31:0] rng_state = 32'd70484;
    string       cur_name;
    bit          cur_rnw;
    int          cur_addr;
    int          cur_len;
    int          exp_cmd_addr;
    int          exp_beats_left;  // Beats not yet seen in a command
    int          checks;
    int          errors;
    int          failed_tests;
    bit          cmp_pending;
    event        run_done;

    always #20 clk = ~clk;

    dma_subsys u_dma_subsys (.*);

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s %s: expected %h, actual %h", cur_name, what, expected, actual);
        end
    endtask

    // Expected memory word k after a write or output word k of a read
    function automatic logic [31:0] ref_word(input bit rnw, input int k);
        logic [31:0] w;
        int          a;
        for (int b = 0; b < 4; b++) begin
            if (rnw) begin
                a = cur_addr + k * 4 + b;
                w[8*b +: 8] = (k * 4 + b < cur_len) ? prior_mem[(a / 4) & 255][8*(a % 4) +: 8]
                                                    : 8'h00;
            end else begin
                a = k * 4 + b - cur_addr;  // Position in the written stream
                w[8*b +: 8] = (a >= 0 && a < cur_len) ? src_bytes[a] : prior_mem[k][8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic expect_outputs_low(input string when);
        check_value({"ready_in ", when}, 0, 32'(ready_in));
        check_value({"valid_out ", when}, 0, 32'(valid_out));
        check_value({"mem_cmd_valid ", when}, 0, 32'(mem_cmd_valid));
        check_value({"mem_wvalid ", when}, 0, 32'(mem_wvalid));
    endtask

    task automatic report_test(input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", cur_name);
        end else begin
            failed_tests++;
            $display("test %s: %0d mismatches", cur_name, errors - errs_before);
        end
    endtask

    // Memory slave and stream ends that sample mid-cycle and act 2 ns after the edge
    always begin : bus_model
        logic        cmd_hs;
        logic        w_hs;
        logic        r_hs;
        logic        in_hs;
        logic        out_hs;
        logic        s_write;
        logic        s_wlast;
        logic [3:0]  s_wstrb;
        logic [3:0]  exp_strb;
        logic [31:0] s_wdata;
        logic [31:0] s_dout;
        int          s_addr;
        int          s_beats;
        int          ba;
        int          bst_addr;
        int          bst_left;
        @(negedge clk);
        cmd_hs  = mem_cmd_valid && mem_cmd_ready;
        w_hs    = mem_wvalid && mem_wready;
        r_hs    = mem_rvalid;
        in_hs   = valid_in && ready_in;
        out_hs  = valid_out && ready_out;
        s_write = mem_cmd_write;
        s_addr  = 32'(mem_cmd_addr);
        s_beats = 32'(mem_cmd_len) + 1;
        s_wdata = mem_wdata;
        s_wstrb = mem_wstrb;
        s_wlast = mem_wlast;
        s_dout  = data_out;
        @(posedge clk);
        #2;
        if (cmd_hs) begin
            check_value("command direction", 32'(!cur_rnw), 32'(s_write));
            check_value("command word address", exp_cmd_addr, s_addr);
            check_value("burst beats", (exp_beats_left > `DMA_MAX_BURST) ? `DMA_MAX_BURST
                                                                         : exp_beats_left,
                        s_beats);
            exp_cmd_addr   += s_beats;
            exp_beats_left -= s_beats;
            bst_addr = s_addr;
            bst_left = s_beats;
        end
        if (w_hs) begin
            for (int b = 0; b < 4; b++) begin
                ba          = bst_addr * 4 + b;
                exp_strb[b] = ba >= cur_addr && ba < cur_addr + cur_len;
                if (s_wstrb[b]) mem[bst_addr & 255][8*b +: 8] = s_wdata[8*b +: 8];
            end
            check_value("write strobe", 32'(exp_strb), 32'(s_wstrb));
            check_value("write last", 32'(bst_left == 1), 32'(s_wlast));
            bst_addr++;
            bst_left--;
        end
        if (r_hs) begin
            bst_addr++;
            bst_left--;
        end
        if (in_hs) void'(in_q.pop_front());
        if (out_hs) rx_q.push_back(s_dout);
        mem_cmd_ready = xorshift32() % 4 != 0;
        mem_wready    = xorshift32() % 4 != 0;
        ready_out     = xorshift32() % 2 != 0;
        if (cur_rnw && bst_left > 0 && xorshift32() % 4 != 0) begin
            mem_rvalid = 1'b1;
            mem_rdata  = mem[bst_addr & 255];
            mem_rlast  = bst_left == 1;  // Final beat of the burst
        end else begin
            mem_rvalid = 1'b0;
            mem_rlast  = 1'b0;
        end
        if (!valid_in || in_hs) begin  // A pending word stays put until taken
            valid_in = in_q.size() != 0 && xorshift32() % 4 != 0;
            data_in  = (in_q.size() != 0) ? in_q[0] : '0;
        end
    end

    always @(run_done) begin : compare_results
        int n_words;
        n_words = (cur_len + 3) / 4;
        check_value("beats never commanded", 0, exp_beats_left);
        if (cur_rnw) begin
            check_value("output word count", n_words, rx_q.size());
            for (int k = 0; k < n_words && k < rx_q.size(); k++)
                check_value($sformatf("output word %0d", k), ref_word(1'b1, k), rx_q[k]);
        end else begin
            for (int k = 0; k < words; k++)
                check_value($sformatf("memory word %0d", k), ref_word(1'b0, k), mem[k]);
        end
        cmp_pending = 1'b0;
    end

    task automatic run_transfer(input string name, input bit rnw, input int a, input int len);
        int          errs_before;
        logic [31:0] w;
        cur_name       = name;
        cur_rnw        = rnw;
        cur_addr       = a;
        cur_len        = len;
        errs_before    = errors;
        exp_cmd_addr   = a / 4;
        exp_beats_left = (a + len - 1) / 4 - a / 4 + 1;  // First to last touched word
        prior_mem      = mem;
        src_bytes.delete();
        rx_q.delete();
        if (!rnw) begin
            for (int i = 0; i < len; i++) src_bytes.push_back(8'(xorshift32()));
            for (int j = 0; j < (len + 3) / 4; j++) begin
                w = '0;
                for (int b = 0; b < 4; b++) begin
                    if (j * 4 + b < len) w[8*b +: 8] = src_bytes[j*4 + b];  // Little endian
                end
                in_q.push_back(w);
            end
        end
        @(posedge clk);
        #2;
        addr           = len_t'(a);
        length         = len_t'(len);
        read_not_write = rnw;
        start          = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        do @(negedge clk); while (!ready);
        cmp_pending = 1'b1;
        -> run_done;
        wait (!cmp_pending);
        report_test(errs_before);
    endtask

    initial begin : main
        int errs_before;
        rst            = 1'b1;
        addr           = '0;
        length         = '0;
        read_not_write = 1'b0;
        start          = 1'b0;
        data_in        = '0;
        valid_in       = 1'b0;
        ready_out      = 1'b0;
        mem_cmd_ready  = 1'b0;
        mem_wready     = 1'b0;
        mem_rdata      = '0;
        mem_rlast      = 1'b0;
        mem_rvalid     = 1'b0;
        for (int i = 0; i < words; i++) mem[i] = 32'(i + 1) * 32'h9e37_79b9;
        cur_name    = "reset_state";
        errs_before = errors;
        repeat (16) begin
            @(negedge clk);
            expect_outputs_low("in reset");
            check_value("ready in reset", 0, 32'(ready));
        end
        @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        @(negedge clk);
        expect_outputs_low("after reset");
        check_value("ready after reset", 1, 32'(ready));
        report_test(errs_before);
        for (int t = 0; t < n_tests; t++) run_transfer(t_name[t], t_rnw[t], t_addr[t], t_len[t]);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests + 1, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // 64 cycles per word of every test plus reset and per-test overhead
    initial begin : watchdog
        int limit;
        limit = 200 + 64 * n_tests;
        for (int i = 0; i < n_tests; i++) limit += 64 * ((t_len[i] + 3) / 4);
        repeat (limit) @(posedge clk);
        $display("timeout: transfers did not finish within %0d cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dma_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_subsys import dma_pkg::*; (
    input  wire                      clk,
    input  wire                      rst,
    input  wire len_t                addr,
    input  wire len_t                length,
    input  wire                      read_not_write,
    input  wire                      start,
    output logic                     ready,
    input  wire [`DMA_DATA_W-1:0]    data_in,
    input  wire                      valid_in,
    output logic                     ready_in,
    output logic [`DMA_DATA_W-1:0]   data_out,
    output logic                     valid_out,
    input  wire                      ready_out,
    output logic                     mem_cmd_valid,
    input  wire                      mem_cmd_ready,
    output logic                     mem_cmd_write,
    output logic [`DMA_LEN_W-3:0]    mem_cmd_addr,
    output burst_len_t               mem_cmd_len,
    output logic [`DMA_DATA_W-1:0]   mem_wdata,
    output logic [`DMA_DATA_W/8-1:0] mem_wstrb,
    output logic                     mem_wlast,
    output logic                     mem_wvalid,
    input  wire                      mem_wready,
    input  wire [`DMA_DATA_W-1:0]    mem_rdata,
    input  wire                      mem_rlast,
    input  wire                      mem_rvalid
);
    logic     wr_start;
    logic     rd_start;
    logic     wr_push;
    wr_beat_t wr_push_data;
    logic     wr_credit_return;
    logic     wr_valid;
    wr_beat_t wr_pop_data;
    logic     wr_pop;
    logic     rd_push;
    rd_beat_t rd_push_data;
    logic     rd_credit_return;
    logic     rd_valid;
    rd_beat_t rd_pop_data;
    logic     rd_pop;
    logic     out_done;

    // Direction-qualified start, seen only while the controller is idle
    assign wr_start = start && ready && !read_not_write;
    assign rd_start = start && ready && read_not_write;
    assign out_done = valid_out && ready_out;

    dma_ctrl u_ctrl (.*);

    burst_pack u_pack (
        .start(wr_start), .push(wr_push), .push_data(wr_push_data),
        .credit_return(wr_credit_return),
        .*
    );

    beat_fifo #(.payload_t(wr_beat_t), .depth(`DMA_FIFO_DEPTH)) u_wr_fifo (
        .clk(clk), .rst(rst),
        .push(wr_push), .push_data(wr_push_data),
        .valid(wr_valid), .pop_data(wr_pop_data), .pop(wr_pop),
        .credit_return(wr_credit_return)
    );

    beat_fifo #(.payload_t(rd_beat_t), .depth(`DMA_FIFO_DEPTH)) u_rd_fifo (
        .clk(clk), .rst(rst),
        .push(rd_push), .push_data(rd_push_data),
        .valid(rd_valid), .pop_data(rd_pop_data), .pop(rd_pop),
        .credit_return(rd_credit_return)
    );

    burst_align u_align (
        .start(rd_start), .valid(rd_valid), .pop_data(rd_pop_data), .pop(rd_pop),
        .*
    );

endmodule

`default_nettype wire

// ==== dma_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module dma_ctrl import dma_pkg::*; (
    input  wire                       clk,
    input  wire                       rst,
    input  wire len_t                 addr,
    input  wire len_t                 length,
    input  wire                       read_not_write,
    input  wire                       start,
    output logic                      ready,
    output logic                      mem_cmd_valid,
    input  wire                       mem_cmd_ready,
    output logic                      mem_cmd_write,
    output logic [`DMA_LEN_W-3:0]     mem_cmd_addr,
    output burst_len_t                mem_cmd_len,
    output logic [`DMA_DATA_W-1:0]    mem_wdata,
    output logic [`DMA_DATA_W/8-1:0]  mem_wstrb,
    output logic                      mem_wlast,
    output logic                      mem_wvalid,
    input  wire                       mem_wready,
    input  wire [`DMA_DATA_W-1:0]     mem_rdata,
    input  wire                       mem_rlast,
    input  wire                       mem_rvalid,
    input  wire                       wr_valid,
    input  wire wr_beat_t             wr_pop_data,
    output logic                      wr_pop,
    output logic                      rd_push,
    output rd_beat_t                  rd_push_data,
    input  wire                       rd_credit_return,
    input  wire                       out_done
);
    localparam int cnt_w  = `DMA_LEN_W - 1;
    localparam int bst_w  = $clog2(`DMA_MAX_BURST + 1);
    localparam int cred_w = $clog2(`DMA_FIFO_DEPTH + 1);

    typedef enum logic [1:0] {st_idle, st_cmd, st_data, st_drain} state_t;

    state_t            state;
    logic              rnw;
    logic [cnt_w-1:0]  beats_left;   // Beats not yet covered by a command
    logic [cnt_w-1:0]  words_left;   // Output words still owed on a read
    logic [bst_w-1:0]  burst_left;
    logic [bst_w-1:0]  burst_beats;
    logic [cred_w-1:0] rd_credits;
    logic              cmd_fire;
    logic              burst_end;

    assign burst_beats   = (beats_left > cnt_w'(`DMA_MAX_BURST)) ? bst_w'(`DMA_MAX_BURST)
                                                                 : bst_w'(beats_left);
    // Reads wait until the whole burst fits in the buffer
    assign mem_cmd_valid = state == st_cmd && (!rnw || rd_credits >= burst_beats);
    assign mem_cmd_write = !rnw;
    assign mem_cmd_len   = burst_len_t'(burst_beats - 1'b1);
    assign cmd_fire      = mem_cmd_valid && mem_cmd_ready;

    assign mem_wvalid = state == st_data && !rnw && wr_valid;
    assign mem_wdata  = wr_pop_data.data;
    assign mem_wstrb  = wr_pop_data.strb;
    assign mem_wlast  = burst_left == 1;
    assign wr_pop     = mem_wvalid && mem_wready;

    assign rd_push           = state == st_data && rnw && mem_rvalid;
    assign rd_push_data.data = mem_rdata;
    assign rd_push_data.last = beats_left == 0 && burst_left == 1;
    assign burst_end         = rnw ? rd_push && mem_rlast : wr_pop && mem_wlast;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= st_idle;
            ready        <= 1'b0;
            rnw          <= 1'b0;
            mem_cmd_addr <= '0;
            beats_left   <= '0;
            words_left   <= '0;
            burst_left   <= '0;
            rd_credits   <= cred_w'(`DMA_FIFO_DEPTH);
        end else begin
            rd_credits <= rd_credits + cred_w'(rd_credit_return)
                          - ((cmd_fire && rnw) ? cred_w'(burst_beats) : '0);
            if (out_done) words_left <= words_left - 1'b1;
            case (state)
                st_idle: begin
                    ready <= 1'b1;
                    if (start && ready) begin
                        ready        <= 1'b0;
                        rnw          <= read_not_write;
                        mem_cmd_addr <= addr[`DMA_LEN_W-1:2];
                        beats_left   <= span_words(addr[1:0], length);
                        words_left   <= span_words(2'd0, length);
                        state        <= st_cmd;
                    end
                end
                st_cmd: if (cmd_fire) begin
                    burst_left   <= burst_beats;
                    beats_left   <= beats_left - cnt_w'(burst_beats);
                    mem_cmd_addr <= mem_cmd_addr + burst_beats;
                    state        <= st_data;
                end
                st_data: begin
                    if (wr_pop || rd_push) burst_left <= burst_left - 1'b1;
                    if (wr_pop && wr_pop_data.last) begin
                        state <= st_idle;
                        ready <= 1'b1;
                    end else if (burst_end) begin
                        state <= (beats_left != 0) ? st_cmd : st_drain;
                    end
                end
                st_drain: if (out_done && words_left == 1) begin  // Aligner handed over the end
                    state <= st_idle;
                    ready <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // A zero count would wrap mem_cmd_len to a full burst
    assert property (@(posedge clk) disable iff (rst)
        mem_cmd_valid |-> burst_beats != 0);
    // Returned credits never outnumber the read buffer entries
    assert property (@(posedge clk) disable iff (rst)
        rd_credits <= cred_w'(`DMA_FIFO_DEPTH));
    // Packer's last flag agrees with the beat count here
    assert property (@(posedge clk) disable iff (rst)
        wr_pop |-> wr_pop_data.last == (beats_left == 0 && burst_left == 1));

endmodule

`default_nettype wire

// ==== burst_align.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module burst_align import dma_pkg::*; (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    input  wire len_t              addr,
    input  wire len_t              length,
    input  wire                    valid,
    input  wire rd_beat_t          pop_data,
    output logic                   pop,
    output logic [`DMA_DATA_W-1:0] data_out,
    output logic                   valid_out,
    input  wire                    ready_out
);
    localparam int data_w = `DMA_DATA_W;

    logic [1:0]            offset;
    logic [1:0]            tail;        // Bytes in a partial final word
    logic                  primed;      // prev holds an earlier beat
    logic                  flush;       // Final word sits in prev only
    logic [`DMA_LEN_W-2:0] words_left;
    logic [data_w-1:0]     prev;
    logic                  can_load;
    logic                  emit;
    logic [4:0]            sh;
    logic [data_w-1:0]     joined;
    logic [data_w-1:0]     word;
    logic [data_w-1:0]     keep;

    assign can_load = !valid_out || ready_out;
    assign pop      = valid && can_load && !flush;
    // With an offset the first beat only primes, unless it is also the last
    assign emit     = pop && (offset == 0 || primed || pop_data.last);
    assign sh       = {offset, 3'b000};

    assign joined = (primed && offset != 0) ? data_w'({pop_data.data, prev} >> sh)
                                            : pop_data.data >> sh;
    assign word   = flush ? prev >> sh : joined;
    assign keep   = (words_left == 1 && tail != 0) ? ~({data_w{1'b1}} << {tail, 3'b000})
                                                   : {data_w{1'b1}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            offset     <= '0;
            tail       <= '0;
            primed     <= 1'b0;
            flush      <= 1'b0;
            words_left <= '0;
            valid_out  <= 1'b0;
        end else begin
            if (valid_out && ready_out) valid_out <= 1'b0;
            if (start) begin
                offset     <= addr[1:0];
                tail       <= length[1:0];
                primed     <= 1'b0;
                flush      <= 1'b0;
                words_left <= span_words(2'd0, length);
            end else if (flush && can_load) begin
                flush      <= 1'b0;
                words_left <= words_left - 1'b1;
                valid_out  <= 1'b1;
            end else if (pop) begin
                primed <= 1'b1;
                flush  <= pop_data.last && words_left != 1;  // The last beat always emits
                if (emit) begin
                    words_left <= words_left - 1'b1;
                    valid_out  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) prev <= pop_data.data;
        if (emit || (flush && can_load)) data_out <= word & keep;  // Unused bytes zero
    end

endmodule

`default_nettype wire

// ==== burst_pack.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module burst_pack import dma_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   start,
    input  wire len_t             addr,
    input  wire len_t             length,
    input  wire [`DMA_DATA_W-1:0] data_in,
    input  wire                   valid_in,
    output logic                  ready_in,
    output logic                  push,
    output wr_beat_t              push_data,
    input  wire                   credit_return
);
    localparam int data_w = `DMA_DATA_W;
    localparam int cred_w = $clog2(`DMA_FIFO_DEPTH + 1);

    logic [1:0]            offset;
    logic [1:0]            end_lane;    // Lane just past the final byte
    logic                  first;
    logic [`DMA_LEN_W-2:0] words_left;  // Input words still to accept
    logic [`DMA_LEN_W-2:0] beats_left;
    logic [data_w-1:0]     carry;
    logic [cred_w-1:0]     credits;
    logic [2*data_w-1:0]   shifted;
    logic [3:0]            lo_strb;
    logic [3:0]            hi_strb;
    logic                  have_credit;

    assign have_credit = credits != 0;
    assign shifted     = {{data_w{1'b0}}, data_in} << {offset, 3'b000};
    assign ready_in    = have_credit && words_left != 0;
    // Final beat may come from the carry alone
    assign push = have_credit && beats_left != 0 && (words_left == 0 || valid_in);

    assign lo_strb = first ? 4'(4'hf << offset) : 4'hf;
    assign hi_strb = (beats_left == 1 && end_lane != 0) ? 4'(4'hf >> (3'd4 - end_lane)) : 4'hf;

    assign push_data.data = (words_left != 0) ? (shifted[data_w-1:0] | carry) : carry;
    assign push_data.strb = lo_strb & hi_strb;
    assign push_data.last = beats_left == 1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            offset     <= '0;
            end_lane   <= '0;
            first      <= 1'b0;
            words_left <= '0;
            beats_left <= '0;
            credits    <= cred_w'(`DMA_FIFO_DEPTH);
        end else begin
            credits <= credits - cred_w'(push) + cred_w'(credit_return);
            if (start) begin
                offset     <= addr[1:0];
                end_lane   <= addr[1:0] + length[1:0];
                first      <= 1'b1;
                words_left <= span_words(2'd0, length);
                beats_left <= span_words(addr[1:0], length);
            end else if (push) begin
                first      <= 1'b0;
                beats_left <= beats_left - 1'b1;
                if (words_left != 0) words_left <= words_left - 1'b1;
            end
        end
    end

    // Upper bytes of the shifted word spill into the next beat
    always_ff @(posedge clk) begin
        if (start) carry <= '0;
        else if (push && words_left != 0) carry <= shifted[2*data_w-1:data_w];
    end

    assert property (@(posedge clk) disable iff (rst) credits <= cred_w'(`DMA_FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== beat_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_defs.svh"

module beat_fifo import dma_pkg::*; #(
    parameter type payload_t = wr_beat_t,
    parameter int  depth     = `DMA_FIFO_DEPTH
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           push,
    input  wire payload_t push_data,
    output logic          valid,
    output payload_t      pop_data,
    input  wire           pop,
    output logic          credit_return
);
    localparam int ptr_w = $clog2(depth);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_pop;

    assign valid    = count != 0;
    assign do_pop   = pop && valid;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= do_pop;  // One credit back per popped beat
            if (push) wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + (ptr_w+1)'(push) - (ptr_w+1)'(do_pop);
        end
    end

    // The producer's credits must keep it off a full buffer
    assert property (@(posedge clk) disable iff (rst) push |-> count < (ptr_w+1)'(depth));
    assert property (@(posedge clk) disable iff (rst) pop |-> valid);

endmodule

`default_nettype wire

// ==== dma_pkg.sv ====
`default_nettype none

`include "dma_defs.svh"

package dma_pkg;

    typedef logic [`DMA_LEN_W-1:0] len_t;

    typedef struct packed {
        logic [`DMA_DATA_W-1:0]   data;
        logic [`DMA_DATA_W/8-1:0] strb;  // Byte enables for the memory write
        logic                     last;  // Final beat of the transfer
    } wr_beat_t;

    typedef struct packed {
        logic [`DMA_DATA_W-1:0] data;
        logic                   last;
    } rd_beat_t;

    typedef logic [$clog2(`DMA_MAX_BURST)-1:0] burst_len_t;

    // Words touched by len bytes that start at byte lane off
    function automatic logic [`DMA_LEN_W-2:0] span_words(input logic [1:0] off, input len_t len);
        logic [`DMA_LEN_W:0] span;
        span = {1'b0, len} + off + 2'd3;
        return span[`DMA_LEN_W:2];
    endfunction

endpackage

`default_nettype wire

// ==== dma_defs.svh ====
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Memory bus word width in bits
`define DMA_DATA_W 32

// Longest burst in beats
`define DMA_MAX_BURST 16

// Beat buffer entries, at least one full burst
`define DMA_FIFO_DEPTH 16

// Byte length and byte address width
`define DMA_LEN_W 12

`endif
